// File: list.f
+incdir+src
src/csr_map_pkg.sv
src/csr_ctrl_pkg.sv
src/csr_wdata_alu.sv
src/csr_counters.sv
src/trap_ctrl.sv
src/csr_regs.sv
src/csr_file.sv
verification/csr_file_tb.sv

// File: src/csr_counters.sv
`include "csr_defs.svh"

module csr_counters (
    input  logic                     CLK,
    input  logic                     RST,
    input  logic                     proc_idle,
    input  logic                     retire,
    input  logic                     csr_we,
    input  csr_map_pkg::csr_addr_e   addr,
    input  logic [`XLEN-1:0]         wdata,
    output logic [63:0]              mcycle,
    output logic [63:0]              minstret
);
    import csr_map_pkg::*;

    logic wr_cycle_lo;
    logic wr_cycle_hi;
    logic wr_instret_lo;
    logic wr_instret_hi;

    // a write to either half replaces it and drops that cycle's increment
    function automatic logic [63:0] next_count(
        input logic [63:0]       cur,
        input logic              inc,
        input logic              wr_lo,
        input logic              wr_hi,
        input logic [`XLEN-1:0]  value
    );
        logic [63:0] nxt;
        nxt = cur;
        if (wr_lo)
            nxt[31:0] = value;
        else if (wr_hi)
            nxt[63:32] = value;
        else if (inc)
            nxt = cur + 64'd1;
        return nxt;
    endfunction

    assign wr_cycle_lo   = csr_we && (addr == csr_mcycle);
    assign wr_cycle_hi   = csr_we && (addr == csr_mcycleh);
    assign wr_instret_lo = csr_we && (addr == csr_minstret);
    assign wr_instret_hi = csr_we && (addr == csr_minstreth);

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            mcycle   <= '0;
            minstret <= '0;
        end
        else
        begin
            mcycle   <= next_count(mcycle, 1'b1, wr_cycle_lo, wr_cycle_hi, wdata);
            minstret <= next_count(minstret, retire, wr_instret_lo, wr_instret_hi, wdata);
        end
    end

    // free-running cycle count
    assert property (@(posedge CLK) disable iff (RST)
        !(wr_cycle_lo || wr_cycle_hi) |=> (mcycle == $past(mcycle) + 64'd1));

    // retire from the trap logic must stay low while the core is idle
    assert property (@(posedge CLK) disable iff (RST)
        proc_idle |=> (minstret == $past(minstret)));

endmodule

// File: src/csr_ctrl_pkg.sv
`include "csr_defs.svh"

package csr_ctrl_pkg;

    // system instruction class decoded by the pipeline
    typedef enum logic [3:0] {
        op_none   = 4'd0,
        op_csrrw  = 4'd1,
        op_csrrs  = 4'd2,
        op_csrrc  = 4'd3,
        op_csrrwi = 4'd4,
        op_csrrsi = 4'd5,
        op_csrrci = 4'd6,
        op_ecall  = 4'd7,
        op_ebreak = 4'd8,
        op_mret   = 4'd9
    } sys_op_e;

    // zimm doubles as the rs1 index for the register forms
    typedef struct packed {
        sys_op_e                 op;
        logic [`CSR_ADDR_W-1:0]  addr;
        logic [`XLEN-1:0]        rs1_data;
        logic [4:0]              zimm;
        logic [`XLEN-1:0]        pc;
    } csr_req_t;

    // synchronous exception raised elsewhere in the pipeline
    typedef struct packed {
        logic                 valid;
        logic [`ECODE_W-1:0]  code;
        logic [`XLEN-1:0]     tval;
    } exc_req_t;

    typedef struct packed {
        logic meip;
        logic mtip;
        logic msip;
    } irq_lines_t;

    // fetch redirect for trap entry and mret
    typedef struct packed {
        logic              taken;
        logic              is_trap;
        logic [`XLEN-1:0]  target;
    } redirect_t;

    function automatic logic is_csr_op(sys_op_e op);
        return op inside {op_csrrw, op_csrrs, op_csrrc, op_csrrwi, op_csrrsi, op_csrrci};
    endfunction

endpackage

// File: src/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// datapath and field widths
`define XLEN        32
`define CSR_ADDR_W  12
`define ECODE_W     31

// RV32I base with the U extension, MXL = 1
`define MISA_VALUE  32'h4010_0100

// synchronous exception codes
`define CAUSE_ILLEGAL   31'd2
`define CAUSE_BREAK     31'd3
`define CAUSE_ECALL_U   31'd8
`define CAUSE_ECALL_M   31'd11

// interrupt codes, reported with the mcause interrupt flag set
`define IRQ_MSI     31'd3
`define IRQ_MTI     31'd7
`define IRQ_MEI     31'd11

`endif

// File: src/csr_file.sv
`include "csr_defs.svh"

module csr_file (
    input  logic                         CLK,
    input  logic                         RST,
    input  csr_ctrl_pkg::csr_req_t       req,
    input  csr_ctrl_pkg::exc_req_t       exc,
    input  csr_ctrl_pkg::irq_lines_t     irq,
    input  logic                         proc_idle,
    output logic [`XLEN-1:0]             rdata,
    output csr_ctrl_pkg::redirect_t      redirect
);
    import csr_map_pkg::*;

    csr_addr_e         csr_addr;
    logic [`XLEN-1:0]  wdata;
    logic [`XLEN-1:0]  mtvec_base;
    logic              wr_intent;
    logic              csr_we;
    logic              retire;
    logic [63:0]       mcycle;
    logic [63:0]       minstret;
    irq_bits_t         irq_en;
    trap_state_t       trap_state;

    assign csr_addr = csr_addr_e'(req.addr);

    // new value from the old one read this cycle
    csr_wdata_alu u_wdata_alu (
        .req        (req),
        .old_value  (rdata),
        .wdata      (wdata),
        .wr_intent  (wr_intent)
    );

    csr_counters u_counters (
        .CLK        (CLK),
        .RST        (RST),
        .proc_idle  (proc_idle),
        .retire     (retire),
        .csr_we     (csr_we),
        .addr       (csr_addr),
        .wdata      (wdata),
        .mcycle     (mcycle),
        .minstret   (minstret)
    );

    trap_ctrl u_trap_ctrl (
        .CLK        (CLK),
        .RST        (RST),
        .req        (req),
        .exc        (exc),
        .irq        (irq),
        .proc_idle  (proc_idle),
        .wr_intent  (wr_intent),
        .wdata      (wdata),
        .mtvec_base (mtvec_base),
        .irq_en     (irq_en),
        .csr_we     (csr_we),
        .retire     (retire),
        .trap_state (trap_state),
        .redirect   (redirect)
    );

    csr_regs u_regs (
        .CLK        (CLK),
        .RST        (RST),
        .addr       (csr_addr),
        .csr_we     (csr_we),
        .wdata      (wdata),
        .irq        (irq),
        .trap_state (trap_state),
        .mcycle     (mcycle),
        .minstret   (minstret),
        .rdata      (rdata),
        .mtvec_base (mtvec_base),
        .irq_en     (irq_en)
    );

endmodule

// File: src/csr_map_pkg.sv
`include "csr_defs.svh"

package csr_map_pkg;

    // machine CSRs plus the read-only user counter aliases
    typedef enum logic [`CSR_ADDR_W-1:0] {
        csr_mstatus   = 12'h300,
        csr_misa      = 12'h301,
        csr_mie       = 12'h304,
        csr_mtvec     = 12'h305,
        csr_mscratch  = 12'h340,
        csr_mepc      = 12'h341,
        csr_mcause    = 12'h342,
        csr_mtval     = 12'h343,
        csr_mip       = 12'h344,
        csr_mcycle    = 12'hB00,
        csr_minstret  = 12'hB02,
        csr_mcycleh   = 12'hB80,
        csr_minstreth = 12'hB82,
        csr_cycle     = 12'hC00,
        csr_instret   = 12'hC02,
        csr_cycleh    = 12'hC80,
        csr_instreth  = 12'hC82,
        csr_mvendorid = 12'hF11,
        csr_marchid   = 12'hF12,
        csr_mimpid    = 12'hF13,
        csr_mhartid   = 12'hF14
    } csr_addr_e;

    typedef enum logic [1:0] {
        priv_u = 2'b00,
        priv_m = 2'b11
    } priv_e;

    // only mie, mpie and mpp are implemented
    typedef struct packed {
        logic [18:0] rsv_31_13;
        logic [1:0]  mpp;
        logic [2:0]  rsv_10_8;
        logic        mpie;
        logic [2:0]  rsv_6_4;
        logic        mie;
        logic [2:0]  rsv_2_0;
    } mstatus_t;

    // shared layout for the mie enables and the mip pending bits
    typedef struct packed {
        logic mei;
        logic mti;
        logic msi;
    } irq_bits_t;

    typedef struct packed {
        mstatus_t          mstatus;
        logic [`XLEN-1:0]  mepc;
        logic [`XLEN-1:0]  mcause;
        logic [`XLEN-1:0]  mtval;
    } trap_state_t;

endpackage

// File: src/csr_regs.sv
`include "csr_defs.svh"

module csr_regs (
    input  logic                         CLK,
    input  logic                         RST,
    input  csr_map_pkg::csr_addr_e       addr,
    input  logic                         csr_we,
    input  logic [`XLEN-1:0]             wdata,
    input  csr_ctrl_pkg::irq_lines_t     irq,
    input  csr_map_pkg::trap_state_t     trap_state,
    input  logic [63:0]                  mcycle,
    input  logic [63:0]                  minstret,
    output logic [`XLEN-1:0]             rdata,
    output logic [`XLEN-1:0]             mtvec_base,
    output csr_map_pkg::irq_bits_t       irq_en
);
    import csr_map_pkg::*;

    logic [`XLEN-1:0] mscratch;
    irq_bits_t        irq_pend;

    // place the three machine bits at 11, 7 and 3
    function automatic logic [`XLEN-1:0] irq_word(input irq_bits_t bits);
        logic [`XLEN-1:0] word;
        word     = '0;
        word[11] = bits.mei;
        word[7]  = bits.mti;
        word[3]  = bits.msi;
        return word;
    endfunction

    // mip follows the interrupt lines directly
    assign irq_pend.mei = irq.meip;
    assign irq_pend.mti = irq.mtip;
    assign irq_pend.msi = irq.msip;

    ////////////////////////////////////////////////////////////////////////////
    // writable machine registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            mscratch   <= '0;
            mtvec_base <= '0;
            irq_en     <= '0;
        end
        else if (csr_we)
        begin
            case (addr)
                csr_mscratch: mscratch <= wdata;
                // direct mode only, mode bits stay zero
                csr_mtvec:    mtvec_base <= {wdata[`XLEN-1:2], 2'b00};
                csr_mie:
                begin
                    irq_en.mei <= wdata[11];
                    irq_en.mti <= wdata[7];
                    irq_en.msi <= wdata[3];
                end
                default:      ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read multiplexer
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (addr)
            csr_mstatus:   rdata = trap_state.mstatus;
            csr_misa:      rdata = `MISA_VALUE;
            csr_mie:       rdata = irq_word(irq_en);
            csr_mtvec:     rdata = mtvec_base;
            csr_mscratch:  rdata = mscratch;
            csr_mepc:      rdata = trap_state.mepc;
            csr_mcause:    rdata = trap_state.mcause;
            csr_mtval:     rdata = trap_state.mtval;
            csr_mip:       rdata = irq_word(irq_pend);
            // user aliases share the machine counters
            csr_mcycle,
            csr_cycle:     rdata = mcycle[31:0];
            csr_mcycleh,
            csr_cycleh:    rdata = mcycle[63:32];
            csr_minstret,
            csr_instret:   rdata = minstret[31:0];
            csr_minstreth,
            csr_instreth:  rdata = minstret[63:32];
            csr_mvendorid,
            csr_marchid,
            csr_mimpid,
            csr_mhartid:   rdata = '0;
            default:       rdata = '0;
        endcase
    end

endmodule

// File: src/csr_wdata_alu.sv
`include "csr_defs.svh"

module csr_wdata_alu (
    input  csr_ctrl_pkg::csr_req_t  req,
    input  logic [`XLEN-1:0]        old_value,
    output logic [`XLEN-1:0]        wdata,
    output logic                    wr_intent
);
    import csr_ctrl_pkg::*;

    logic [`XLEN-1:0] operand;

    // register forms take rs1, immediate forms the zero-extended zimm
    always_comb
    begin
        case (req.op)
            op_csrrw, op_csrrs, op_csrrc: operand = req.rs1_data;
            default:                      operand = {{(`XLEN-5){1'b0}}, req.zimm};
        endcase
    end

    always_comb
    begin
        wdata     = old_value;
        wr_intent = 1'b0;
        case (req.op)
            op_csrrw, op_csrrwi:
            begin
                wdata     = operand;
                wr_intent = 1'b1;
            end
            op_csrrs, op_csrrsi:
            begin
                wdata     = old_value | operand;
                wr_intent = |req.zimm;
            end
            op_csrrc, op_csrrci:
            begin
                wdata     = old_value & ~operand;
                wr_intent = |req.zimm;
            end
            default:
            begin
                wdata     = old_value;
                wr_intent = 1'b0;
            end
        endcase
    end

    always_comb
    begin
        assert final (!(wr_intent && !is_csr_op(req.op)))
            else $error("write intent raised for a non-CSR opcode");
    end

endmodule

// File: src/trap_ctrl.sv
`include "csr_defs.svh"

module trap_ctrl (
    input  logic                         CLK,
    input  logic                         RST,
    input  csr_ctrl_pkg::csr_req_t       req,
    input  csr_ctrl_pkg::exc_req_t       exc,
    input  csr_ctrl_pkg::irq_lines_t     irq,
    input  logic                         proc_idle,
    input  logic                         wr_intent,
    input  logic [`XLEN-1:0]             wdata,
    input  logic [`XLEN-1:0]             mtvec_base,
    input  csr_map_pkg::irq_bits_t       irq_en,
    output logic                         csr_we,
    output logic                         retire,
    output csr_map_pkg::trap_state_t     trap_state,
    output csr_ctrl_pkg::redirect_t      redirect
);
    import csr_map_pkg::*;
    import csr_ctrl_pkg::*;

    priv_e                priv;
    mstatus_t             mstatus;
    logic [`XLEN-1:0]     mepc;
    logic [`XLEN-1:0]     mtval;
    logic                 mcause_irq;
    logic [`ECODE_W-1:0]  mcause_code;

    logic                 pend_mei;
    logic                 pend_msi;
    logic                 pend_mti;
    logic                 illegal;
    logic                 take_trap;
    logic                 do_mret;
    logic                 cause_irq;
    logic [`ECODE_W-1:0]  cause_code;
    logic [`XLEN-1:0]     cause_tval;

    ////////////////////////////////////////////////////////////////////////////
    // cause selection
    ////////////////////////////////////////////////////////////////////////////

    assign pend_mei = mstatus.mie && irq_en.mei && irq.meip;
    assign pend_msi = mstatus.mie && irq_en.msi && irq.msip;
    assign pend_mti = mstatus.mie && irq_en.mti && irq.mtip;

    // privilege too low, or a write to a read-only address
    assign illegal = is_csr_op(req.op)
                  && ((req.addr[9:8] > priv) || (wr_intent && (&req.addr[11:10])));

    // external > software > timer > any synchronous cause
    always_comb
    begin
        take_trap  = 1'b1;
        cause_irq  = 1'b0;
        cause_code = '0;
        cause_tval = '0;
        if (pend_mei)
        begin
            cause_irq  = 1'b1;
            cause_code = `IRQ_MEI;
        end
        else if (pend_msi)
        begin
            cause_irq  = 1'b1;
            cause_code = `IRQ_MSI;
        end
        else if (pend_mti)
        begin
            cause_irq  = 1'b1;
            cause_code = `IRQ_MTI;
        end
        else if (exc.valid)
        begin
            cause_code = exc.code;
            cause_tval = exc.tval;
        end
        else if (illegal)
            cause_code = `CAUSE_ILLEGAL;
        else if (req.op == op_ecall)
            cause_code = (priv == priv_u) ? `CAUSE_ECALL_U : `CAUSE_ECALL_M;
        else if (req.op == op_ebreak)
            cause_code = `CAUSE_BREAK;
        else
            take_trap = 1'b0;
        if (proc_idle)
            take_trap = 1'b0;
    end

    assign do_mret = (req.op == op_mret) && !proc_idle && !take_trap;
    assign csr_we  = wr_intent && !proc_idle && !take_trap;
    assign retire  = !proc_idle && !take_trap;

    assign redirect.taken   = take_trap || do_mret;
    assign redirect.is_trap = take_trap;
    assign redirect.target  = take_trap ? mtvec_base : (do_mret ? mepc : '0);

    ////////////////////////////////////////////////////////////////////////////
    // privilege and trap CSR state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            priv        <= priv_m;
            mstatus     <= '{mpp: priv_m, default: '0};
            mepc        <= '0;
            mtval       <= '0;
            mcause_irq  <= 1'b0;
            mcause_code <= '0;
        end
        else if (take_trap)
        begin
            mepc         <= req.pc;
            mcause_irq   <= cause_irq;
            mcause_code  <= cause_code;
            mtval        <= cause_tval;
            mstatus.mpie <= mstatus.mie;
            mstatus.mie  <= 1'b0;
            mstatus.mpp  <= priv;
            priv         <= priv_m;
        end
        else if (do_mret)
        begin
            priv         <= priv_e'(mstatus.mpp);
            mstatus.mie  <= mstatus.mpie;
            mstatus.mpie <= 1'b1;
            mstatus.mpp  <= priv_u;
        end
        else if (csr_we)
        begin
            case (req.addr)
                csr_mstatus:
                begin
                    mstatus.mie  <= wdata[3];
                    mstatus.mpie <= wdata[7];
                    // only U and M exist, anything else falls back to U
                    mstatus.mpp  <= (wdata[12:11] == priv_m) ? priv_m : priv_u;
                end
                csr_mepc:   mepc <= wdata;
                csr_mcause: {mcause_irq, mcause_code} <= wdata;
                csr_mtval:  mtval <= wdata;
                default:    ;
            endcase
        end
    end

    assign trap_state.mstatus = mstatus;
    assign trap_state.mepc    = mepc;
    assign trap_state.mcause  = {mcause_irq, mcause_code};
    assign trap_state.mtval   = mtval;

    // mtvec alignment is kept by csr_regs
    assert property (@(posedge CLK) disable iff (RST)
        redirect.is_trap |-> (redirect.target[1:0] == 2'b00));

    assert property (@(posedge CLK) disable iff (RST)
        !(csr_we && redirect.is_trap));

endmodule

// File: verification/csr_file_tb.sv
`include "csr_defs.svh"

module csr_file_tb;
    import csr_map_pkg::*;
    import csr_ctrl_pkg::*;

    // run limit in cycles
    localparam int MAX_CYCLES = 2000;

    logic              CLK;
    logic              RST;
    csr_req_t          req;
    exc_req_t          exc;
    irq_lines_t        irq;
    logic              proc_idle;
    logic [`XLEN-1:0]  rdata;
    redirect_t         redirect;

    // reference model state
    logic [1:0]   m_priv;
    logic         m_mie;
    logic         m_mpie;
    logic [1:0]   m_mpp;
    logic [31:0]  m_mepc;
    logic [31:0]  m_mcause;
    logic [31:0]  m_mtval;
    logic [31:0]  m_mtvec;
    logic [31:0]  m_scratch;
    logic [2:0]   m_en;
    logic [63:0]  m_cycle;
    logic [63:0]  m_instret;

    logic [31:0]  exp_rdata;
    redirect_t    exp_redirect;
    logic         chk;
    string        test_name;
    int           error_count;
    int           check_count;
    int           cycle_count;
    logic [31:0]  pc_next;

    csr_file u_csr_file (
        .CLK       (CLK),
        .RST       (RST),
        .req       (req),
        .exc       (exc),
        .irq       (irq),
        .proc_idle (proc_idle),
        .rdata     (rdata),
        .redirect  (redirect)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES)
        begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    assert property (@(posedge CLK) disable iff (RST) chk |-> (rdata == exp_rdata))
    else
    begin
        error_count++;
        $display("MISMATCH %s rdata expected %h actual %h",
                 test_name, $sampled(exp_rdata), $sampled(rdata));
    end

    assert property (@(posedge CLK) disable iff (RST) chk |-> (redirect == exp_redirect))
    else
    begin
        error_count++;
        $display("MISMATCH %s redirect expected %h actual %h",
                 test_name, $sampled(exp_redirect), $sampled(redirect));
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic model_reset();
        m_priv    = 2'b11;
        m_mie     = 1'b0;
        m_mpie    = 1'b0;
        m_mpp     = 2'b11;
        m_mepc    = '0;
        m_mcause  = '0;
        m_mtval   = '0;
        m_mtvec   = '0;
        m_scratch = '0;
        m_en      = '0;
        m_cycle   = '0;
        m_instret = '0;
    endtask

    function automatic logic [31:0] model_read(input logic [11:0] a);
        logic [31:0] v;
        v = '0;
        case (a)
            12'h300: v = {19'b0, m_mpp, 3'b0, m_mpie, 3'b0, m_mie, 3'b0};
            12'h301: v = `MISA_VALUE;
            12'h304: v = {20'b0, m_en[2], 3'b0, m_en[1], 3'b0, m_en[0], 3'b0};
            12'h305: v = m_mtvec;
            12'h340: v = m_scratch;
            12'h341: v = m_mepc;
            12'h342: v = m_mcause;
            12'h343: v = m_mtval;
            12'h344: v = {20'b0, irq.meip, 3'b0, irq.mtip, 3'b0, irq.msip, 3'b0};
            12'hB00, 12'hC00: v = m_cycle[31:0];
            12'hB80, 12'hC80: v = m_cycle[63:32];
            12'hB02, 12'hC02: v = m_instret[31:0];
            12'hB82, 12'hC82: v = m_instret[63:32];
            default: v = '0;
        endcase
        return v;
    endfunction

    task automatic model_write(input logic [11:0] a, input logic [31:0] w);
        case (a)
            12'h300:
            begin
                m_mie  = w[3];
                m_mpie = w[7];
                m_mpp  = (w[12:11] == 2'b11) ? 2'b11 : 2'b00;
            end
            12'h304: m_en = {w[11], w[7], w[3]};
            12'h305: m_mtvec = {w[31:2], 2'b00};
            12'h340: m_scratch = w;
            12'h341: m_mepc = w;
            12'h342: m_mcause = w;
            12'h343: m_mtval = w;
            default: ;
        endcase
    endtask

    // one instruction per cycle from a falling edge
    task automatic step(input sys_op_e op, input logic [11:0] addr, input logic [31:0] rs1,
                        input logic [4:0] zimm, input irq_lines_t lines, input exc_req_t e,
                        input logic idle);
        logic [31:0] old;
        logic [31:0] operand;
        logic [31:0] wd;
        logic [31:0] cause;
        logic [31:0] tval;
        logic        intent;
        logic        illegal;
        logic        trap;
        logic        mret;
        logic        we;
        req       = '{op: op, addr: addr, rs1_data: rs1, zimm: zimm, pc: pc_next};
        exc       = e;
        irq       = lines;
        proc_idle = idle;
        old     = model_read(addr);
        operand = (op inside {op_csrrw, op_csrrs, op_csrrc}) ? rs1 : {27'b0, zimm};
        wd      = old;
        intent  = 1'b0;
        case (op)
            op_csrrw, op_csrrwi:
            begin
                wd     = operand;
                intent = 1'b1;
            end
            op_csrrs, op_csrrsi:
            begin
                wd     = old | operand;
                intent = |zimm;
            end
            op_csrrc, op_csrrci:
            begin
                wd     = old & ~operand;
                intent = |zimm;
            end
            default: ;
        endcase
        illegal = (op inside {op_csrrw, op_csrrs, op_csrrc, op_csrrwi, op_csrrsi, op_csrrci})
               && ((addr[9:8] > m_priv) || (intent && (&addr[11:10])));
        // interrupts first, then the synchronous causes
        trap = 1'b1;
        tval = '0;
        if (m_mie && m_en[2] && lines.meip)
            cause = {1'b1, `IRQ_MEI};
        else if (m_mie && m_en[0] && lines.msip)
            cause = {1'b1, `IRQ_MSI};
        else if (m_mie && m_en[1] && lines.mtip)
            cause = {1'b1, `IRQ_MTI};
        else if (e.valid)
        begin
            cause = {1'b0, e.code};
            tval  = e.tval;
        end
        else if (illegal)
            cause = {1'b0, `CAUSE_ILLEGAL};
        else if (op == op_ecall)
            cause = {1'b0, ((m_priv == 2'b00) ? `CAUSE_ECALL_U : `CAUSE_ECALL_M)};
        else if (op == op_ebreak)
            cause = {1'b0, `CAUSE_BREAK};
        else
        begin
            trap  = 1'b0;
            cause = '0;
        end
        trap = trap && !idle;
        mret = (op == op_mret) && !idle && !trap;
        we   = intent && !idle && !trap;
        exp_rdata    = old;
        exp_redirect = '{taken: trap || mret, is_trap: trap,
                         target: trap ? m_mtvec : (mret ? m_mepc : 32'h0)};
        chk = 1'b1;
        check_count++;
        @(posedge CLK);
        if (trap)
        begin
            m_mepc   = pc_next;
            m_mcause = cause;
            m_mtval  = tval;
            m_mpie   = m_mie;
            m_mie    = 1'b0;
            m_mpp    = m_priv;
            m_priv   = 2'b11;
        end
        else if (mret)
        begin
            m_priv = m_mpp;
            m_mie  = m_mpie;
            m_mpie = 1'b1;
            m_mpp  = 2'b00;
        end
        else if (we)
            model_write(addr, wd);
        // a counter write replaces one half and drops that cycle's increment
        if (we && addr == 12'hB00)
            m_cycle[31:0] = wd;
        else if (we && addr == 12'hB80)
            m_cycle[63:32] = wd;
        else
            m_cycle++;
        if (we && addr == 12'hB02)
            m_instret[31:0] = wd;
        else if (we && addr == 12'hB82)
            m_instret[63:32] = wd;
        else if (!idle && !trap)
            m_instret++;
        pc_next = pc_next + 32'd4;
        @(negedge CLK);
    endtask

    task automatic csr_op(input sys_op_e op, input logic [11:0] addr, input logic [31:0] rs1,
                          input logic [4:0] zimm);
        step(op, addr, rs1, zimm, 3'b000, '0, 1'b0);
    endtask

    task automatic read_csr(input logic [11:0] addr);
        step(op_csrrs, addr, 32'h0, 5'd0, 3'b000, '0, 1'b0);
    endtask

    task automatic sys_op(input sys_op_e op);
        step(op, 12'h000, 32'h0, 5'd0, 3'b000, '0, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        sys_op_e op;
        void'($urandom(32'h3445_441c));
        RST         = 1'b1;
        req         = '0;
        exc         = '0;
        irq         = '0;
        proc_idle   = 1'b0;
        chk         = 1'b0;
        error_count = 0;
        check_count = 0;
        pc_next     = 32'h0000_0100;
        test_name   = "reset";
        model_reset();
        repeat (8) @(negedge CLK);
        RST = 1'b0;

        read_csr(12'h300);
        read_csr(12'h301);
        for (int a = 12'hF11; a <= 12'hF14; a++)
            read_csr(a[11:0]);
        repeat (4) read_csr(12'hB00);

        test_name = "csr_ops";
        for (int k = 0; k < 18; k++)
        begin
            op = sys_op_e'((k % 6) + 1);
            csr_op(op, 12'h340, $urandom, 5'($urandom));
            read_csr(12'h340);
        end
        // set and clear with a zero source field write nothing
        csr_op(op_csrrs, 12'h340, 32'hFFFF_FFFF, 5'd0);
        csr_op(op_csrrc, 12'h340, 32'hFFFF_FFFF, 5'd0);
        csr_op(op_csrrsi, 12'h340, 32'h0, 5'd0);
        csr_op(op_csrrci, 12'h340, 32'h0, 5'd0);
        read_csr(12'h340);

        test_name = "counters";
        csr_op(op_csrrw, 12'hB02, 32'h0000_1000, 5'd1);
        repeat (4) step(op_csrrs, 12'hB02, 32'h0, 5'd0, 3'b000, '0, 1'b1);
        step(op_csrrw, 12'h340, $urandom, 5'd1, 3'b000, '0, 1'b1);
        repeat (4) read_csr(12'hB02);
        read_csr(12'hC02);
        read_csr(12'h340);
        csr_op(op_csrrw, 12'hB80, 32'h0000_00A5, 5'd1);
        read_csr(12'hC80);
        read_csr(12'hC00);

        test_name = "ecall_mret";
        csr_op(op_csrrw, 12'h305, $urandom, 5'd1);
        csr_op(op_csrrw, 12'h300, 32'h0000_1808, 5'd1);
        sys_op(op_ecall);
        read_csr(12'h342);
        read_csr(12'h341);
        read_csr(12'h300);
        sys_op(op_mret);
        read_csr(12'h300);
        sys_op(op_ebreak);
        read_csr(12'h342);
        sys_op(op_mret);
        step(op_none, 12'h000, 32'h0, 5'd0, 3'b000, '{valid: 1'b1, code: 31'd5, tval: $urandom},
             1'b0);
        read_csr(12'h342);
        read_csr(12'h343);
        sys_op(op_mret);

        test_name = "irq_priority";
        csr_op(op_csrrw, 12'h304, 32'h0000_0888, 5'd1);
        csr_op(op_csrrw, 12'h300, 32'h0000_1808, 5'd1);
        step(op_none, 12'h000, 32'h0, 5'd0, 3'b110, '0, 1'b0);
        read_csr(12'h342);
        step(op_csrrs, 12'h344, 32'h0, 5'd0, 3'b111, '0, 1'b0);
        sys_op(op_mret);
        step(op_none, 12'h000, 32'h0, 5'd0, 3'b010, '0, 1'b0);
        read_csr(12'h342);
        sys_op(op_mret);
        // pipeline exception raised with a software interrupt
        step(op_none, 12'h000, 32'h0, 5'd0, 3'b001,
             '{valid: 1'b1, code: 31'd5, tval: 32'hDEAD_BEEF}, 1'b0);
        read_csr(12'h342);
        read_csr(12'h343);
        sys_op(op_mret);
        csr_op(op_csrrw, 12'h304, 32'h0, 5'd1);

        test_name = "user_mode";
        csr_op(op_csrrw, 12'h300, 32'h0, 5'd1);
        sys_op(op_mret);
        csr_op(op_csrrw, 12'h340, $urandom, 5'd1);
        read_csr(12'h342);
        read_csr(12'h340);
        sys_op(op_mret);
        read_csr(12'hC00);
        sys_op(op_ecall);
        read_csr(12'h342);
        read_csr(12'h300);

        chk = 1'b0;
        $display("checks: %0d errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
